/* tests/tpl_adc_trace.txt */
# W adr data | R adr expect mask | B count valid data expect exp_valid
# S sync pulse | E ext_enable | I idle_cycles (all numbers hex except counts)
R 01 00000030 ffffffff
W 04 ffffffff
R 04 000000f7 ffffffff
R 00 00000000 ffffffff
W 04 00000000
W 05 00000003
B 1 1 fedcba9812345678 f73fe62e0d041e15 1
B 1 1 11223344ffffffff 0884110c3fff3fff 1
W 04 00000005
B 2 1 fedcba9812345678 f73fe62e2d043e15 1
B 2 0 0 0 0
B 1 1 11223344ffffffff 0884110c1fff1fff 1
I 3
E 1
W 00 00000001
R 01 00000001 00000001
B 3 1 fedcba9812345678 f73fe62e2d043e15 0
S
I 2
R 01 00000000 00000001
W 00 00000001
R 01 00000001 00000001
W 00 00000004
R 01 00000000 00000001
E 0
W 00 00000001
R 01 00000000 00000001
W 04 00000000
W 05 00000000
B 4 1 0 0 1
W 04 00000010
W 05 00000020
B 20 1 0 0 1
I 4
R 01 00000000 00000331
B 1 1 0000001000000010 0000040000000400 1
I 4
R 01 00000300 00000331
W 01 00000300
R 01 00000000 00000331
B 16 1 0000001000000010 0000040000000400 1
I 4
R 01 00000330 00000331
W 04 000000f0
W 05 000000f0
W 01 00000300
B 20 1 0 0 1
I 4
R 01 00000030 00000331

/* files.f */
hdl/tpl_adc_pkg.sv
hdl/tpl_adc_deframer.sv
hdl/tpl_adc_pn_monitor.sv
hdl/tpl_adc_channel.sv
hdl/tpl_adc_ext_sync.sv
hdl/tpl_adc_regs.sv
hdl/tpl_adc_core.sv
tests/tpl_adc_sva.sv
tests/tb_tpl_adc.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert
TOP ?= tb_tpl_adc
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
PASS_MSG := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* tests/tb_tpl_adc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tpl_adc import tpl_adc_pkg::*; ();

  localparam int max_ops = 128;

  logic clk;
  logic rst;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [7:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic wb_ack;
  logic link_valid;
  logic [3:0] link_sof;
  logic [63:0] link_data;
  logic adc_sync_in;
  logic adc_ext_sync_enable;
  logic [1:0] adc_valid;
  logic [63:0] adc_data;
  logic adc_sync_status;
  logic adc_rst_sync;

  // Operations parsed from the trace with columns that differ per kind
  string op_kind [max_ops];
  logic [63:0] op_a [max_ops];
  logic [63:0] op_b [max_ops];
  logic [63:0] op_c [max_ops];
  logic [63:0] op_d [max_ops];
  logic [63:0] op_e [max_ops];
  int n_ops = 0;

  // Expected output for the beat driven on this edge is delayed two cycles below
  logic drv_valid;
  logic drv_chk;
  logic [63:0] drv_exp;
  logic p1_valid = 1'b0;
  logic p1_chk = 1'b0;
  logic [63:0] p1_exp = '0;
  logic p2_valid = 1'b0;
  logic p2_chk = 1'b0;
  logic [63:0] p2_exp = '0;

  // Expected state of the sync gate as seen on the status outputs
  logic exp_armed = 1'b0;

  tpl_adc_core tpl_adc_core_inst (
    .clk (clk),
    .rst (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_we (wb_we),
    .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack (wb_ack),
    .link_valid (link_valid),
    .link_sof (link_sof),
    .link_data (link_data),
    .adc_sync_in (adc_sync_in),
    .adc_ext_sync_enable (adc_ext_sync_enable),
    .adc_valid (adc_valid),
    .adc_data (adc_data),
    .adc_sync_status (adc_sync_status),
    .adc_rst_sync (adc_rst_sync)
  );

  always #10 clk = ~clk;

  // **********************************************************************
  // Failure reporting and the single compare task
  // **********************************************************************

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h",
                               name, actual, expected));
    end
  endtask

  // **********************************************************************
  // Output checker with a two-stage expectation pipeline matching the DUT latency
  // **********************************************************************

  always @(posedge clk) begin
    p1_valid <= drv_valid;
    p1_chk <= drv_chk;
    p1_exp <= drv_exp;
    p2_valid <= p1_valid;
    p2_chk <= p1_chk;
    p2_exp <= p1_exp;
  end

  // Outputs settle after the rising edge, so they are compared on the falling one
  always @(negedge clk) begin
    if (!rst) begin
      check_value("adc_valid", 64'(adc_valid), {62'd0, p2_valid, p2_valid});
      check_value("adc_sync_status", 64'(adc_sync_status), 64'(exp_armed));
      check_value("adc_rst_sync", 64'(adc_rst_sync), 64'(exp_armed));
      if (p2_chk) begin
        check_value("adc_data", adc_data, p2_exp);
      end
    end
  end

  // **********************************************************************
  // Bus and link drivers
  // **********************************************************************

  // Master holds the request until ack, then drops it on the following edge
  task automatic bus_access(input logic we, input logic [7:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= we;
    wb_adr <= adr;
    wb_dat_w <= wdata;
    @(negedge clk);
    while (!wb_ack) begin
      @(negedge clk);
    end
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
  endtask

  // Back-to-back beats are followed by one cycle with link_valid low
  task automatic drive_beats(input int count, input logic valid, input logic [63:0] data,
                             input logic [63:0] exp_data, input logic exp_valid);
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
      link_valid <= valid;
      link_data <= data;
      drv_valid <= exp_valid;
      drv_chk <= valid;
      drv_exp <= exp_data;
    end
    @(posedge clk);
    link_valid <= 1'b0;
    drv_valid <= 1'b0;
    drv_chk <= 1'b0;
  endtask

  // A short high level gives the gate one rising edge
  task automatic pulse_sync();
    @(posedge clk);
    adc_sync_in <= 1'b1;
    @(posedge clk);
    // The gate sees the rising edge now and releases on this edge
    if (adc_ext_sync_enable) begin
      exp_armed = 1'b0;
    end
    @(posedge clk);
    adc_sync_in <= 1'b0;
  endtask

  // **********************************************************************
  // Trace parsing and execution
  // **********************************************************************

  task automatic read_trace();
    int fd;
    int code;
    string tok;
    string line;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    logic [63:0] d;
    logic [63:0] e;
    fd = $fopen("tests/tpl_adc_trace.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open the trace file tests/tpl_adc_trace.txt");
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %s", tok);
      if (code != 1) begin
        break;
      end
      a = '0;
      b = '0;
      c = '0;
      d = '0;
      e = '0;
      if (tok.substr(0, 0) == "#") begin
        // Comment lines run to the end of the line
        code = $fgets(line, fd);
        continue;
      end else if (tok == "W") begin
        code = $fscanf(fd, " %h %h", a, b);
      end else if (tok == "R") begin
        code = $fscanf(fd, " %h %h %h", a, b, c);
      end else if (tok == "B") begin
        code = $fscanf(fd, " %d %h %h %h %h", a, b, c, d, e);
      end else if (tok == "E") begin
        code = $fscanf(fd, " %h", a);
      end else if (tok == "I") begin
        code = $fscanf(fd, " %d", a);
      end else if (tok != "S") begin
        report_failure($sformatf("Unknown operation '%s' in the trace", tok));
      end
      if (n_ops >= max_ops) begin
        report_failure("The trace holds more operations than the testbench can store");
      end
      op_kind[n_ops] = tok;
      op_a[n_ops] = a;
      op_b[n_ops] = b;
      op_c[n_ops] = c;
      op_d[n_ops] = d;
      op_e[n_ops] = e;
      n_ops++;
    end
    $fclose(fd);
    if (n_ops == 0) begin
      report_failure("The trace file holds no operations");
    end
  endtask

  task automatic run_op(input int i);
    logic [31:0] rdata;
    if (op_kind[i] == "W") begin
      bus_access(1'b1, op_a[i][7:0], op_b[i][31:0], rdata);
      if (op_a[i][7:0] == reg_ctrl_addr_c) begin
        // Disarm and manual sync release the gate, while arming needs the external enable
        if (op_b[i][1] || op_b[i][2]) begin
          exp_armed = 1'b0;
        end else if (op_b[i][0] && adc_ext_sync_enable) begin
          exp_armed = 1'b1;
        end
      end
    end else if (op_kind[i] == "R") begin
      bus_access(1'b0, op_a[i][7:0], 32'd0, rdata);
      // Only the fields under the mask are defined
      check_value($sformatf("wb_dat_r[0x%0h]", op_a[i][7:0]),
                  {32'd0, rdata & op_c[i][31:0]}, {32'd0, op_b[i][31:0] & op_c[i][31:0]});
    end else if (op_kind[i] == "B") begin
      drive_beats(int'(op_a[i]), op_b[i][0], op_c[i], op_d[i], op_e[i][0]);
    end else if (op_kind[i] == "S") begin
      pulse_sync();
    end else if (op_kind[i] == "E") begin
      @(posedge clk);
      adc_ext_sync_enable <= op_a[i][0];
    end else begin
      repeat (int'(op_a[i])) @(posedge clk);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    link_valid = 1'b0;
    link_sof = '0;
    link_data = '0;
    adc_sync_in = 1'b0;
    adc_ext_sync_enable = 1'b0;
    drv_valid = 1'b0;
    drv_chk = 1'b0;
    drv_exp = '0;
    read_trace();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_ops; i++) begin
      run_op(i);
    end
    // Let the last beats drain through the checker
    repeat (4) @(posedge clk);
    $display("*** PASSED ***");
    $finish;
  end

  // Budget of 40 cycles per trace line on top of a fixed margin
  initial begin
    // The trace is fully read at time zero, before the first clock edge
    @(posedge clk);
    repeat (40 * n_ops + 200) @(posedge clk);
    report_failure("Timeout: the trace did not finish within the cycle limit");
  end

endmodule

`default_nettype wire

/* tests/tpl_adc_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module tpl_adc_sva import tpl_adc_pkg::*; (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_we,
  input logic wb_ack,
  input logic link_valid,
  input logic [num_channels_c-1:0] adc_valid,
  input logic adc_sync_status,
  input logic adc_rst_sync
);

  // **********************************************************************
  // Wishbone handshake
  // **********************************************************************

  // Ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
    else $error("wb_ack held for more than one cycle");

  // Ack only answers a live request
  ack_in_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_cyc && wb_stb)
    else $error("wb_ack outside a bus cycle");

  // **********************************************************************
  // Sync gate
  // **********************************************************************

  // Valid trails link_valid by two cycles and stays low while the gate is armed
  valid_gated: assert property (@(posedge clk) disable iff (rst)
    adc_valid == {num_channels_c{$past(link_valid, 2) & ~adc_sync_status}})
    else $error("adc_valid does not follow link_valid or is high while armed");

  // Both sync outputs rise together and only on the cycle after a register write
  rst_sync_match: assert property (@(posedge clk) disable iff (rst)
    $rose(adc_rst_sync) |-> adc_sync_status && $past(wb_ack && wb_we))
    else $error("adc_rst_sync rose apart from adc_sync_status or without a write");

endmodule

bind tpl_adc_core tpl_adc_sva sva_inst (
  .clk (clk),
  .rst (rst),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_we (wb_we),
  .wb_ack (wb_ack),
  .link_valid (link_valid),
  .adc_valid (adc_valid),
  .adc_sync_status (adc_sync_status),
  .adc_rst_sync (adc_rst_sync)
);

`default_nettype wire

/* hdl/tpl_adc_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tpl_adc_core import tpl_adc_pkg::*; #(
  parameter int num_lanes = num_lanes_c,
  parameter int num_channels = num_channels_c,
  parameter int octets_per_beat = octets_per_beat_c,
  parameter int resolution = resolution_c,
  parameter int sample_bits = sample_bits_c
) (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_we,
  input logic [7:0] wb_adr,
  input logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic wb_ack,
  input logic link_valid,
  // Start of frame is taken in but frame alignment is not implemented
  input logic [octets_per_beat-1:0] link_sof,
  input logic [num_lanes*octets_per_beat*8-1:0] link_data,
  input logic adc_sync_in,
  input logic adc_ext_sync_enable,
  output logic [num_channels-1:0] adc_valid,
  output logic [num_channels*samples_per_beat_c*sample_bits-1:0] adc_data,
  output logic adc_sync_status,
  output logic adc_rst_sync
);

  localparam int raw_chan_w = samples_per_beat_c * resolution;
  localparam int fmt_chan_w = samples_per_beat_c * sample_bits;

  logic [num_channels*raw_chan_w-1:0] raw_data;
  logic link_valid_d;
  logic link_valid_dd;
  logic armed;
  logic sync_arm;
  logic sync_disarm;
  logic sync_manual;
  logic [num_channels-1:0] fmt_enable;
  logic [num_channels-1:0] sign_extend;
  logic [num_channels-1:0] fmt_type;
  logic [num_channels*4-1:0] pn_sel;
  logic [num_channels-1:0] pn_err;
  logic [num_channels-1:0] pn_oos;

  // Valid follows the two data stages, deframer then channel
  always_ff @(posedge clk) begin
    if (rst) begin
      link_valid_d <= 1'b0;
      link_valid_dd <= 1'b0;
    end else begin
      link_valid_d <= link_valid;
      link_valid_dd <= link_valid_d;
    end
  end

  // The armed gate holds the stream back from the DMA side
  assign adc_valid = {num_channels{link_valid_dd & ~armed}};
  assign adc_sync_status = armed;
  assign adc_rst_sync = armed;

  tpl_adc_deframer #(
    .num_lanes (num_lanes),
    .num_channels (num_channels),
    .octets_per_beat (octets_per_beat),
    .resolution (resolution),
    .sample_bits (sample_bits)
  ) deframer_inst (
    .clk (clk),
    .rst (rst),
    .link_data (link_data),
    .raw_data (raw_data)
  );

  tpl_adc_regs #(
    .num_channels (num_channels)
  ) regs_inst (
    .clk (clk),
    .rst (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_we (wb_we),
    .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack (wb_ack),
    .chan_fmt_enable (fmt_enable),
    .chan_sign_extend (sign_extend),
    .chan_fmt_type (fmt_type),
    .chan_pn_sel (pn_sel),
    .sync_arm (sync_arm),
    .sync_disarm (sync_disarm),
    .sync_manual (sync_manual),
    .sync_armed (armed),
    .pn_err (pn_err),
    .pn_oos (pn_oos)
  );

  tpl_adc_ext_sync ext_sync_inst (
    .clk (clk),
    .rst (rst),
    .arm (sync_arm),
    .disarm (sync_disarm),
    .manual_req (sync_manual),
    .ext_enable (adc_ext_sync_enable),
    .sync_in (adc_sync_in),
    .armed (armed)
  );

  // PN checking runs on the ungated valid so it also works while armed
  for (genvar c = 0; c < num_channels; c++) begin : g_channel
    tpl_adc_channel #(
      .resolution (resolution),
      .sample_bits (sample_bits)
    ) channel_inst (
      .clk (clk),
      .rst (rst),
      .valid (link_valid_dd),
      .raw_data (raw_data[c*raw_chan_w +: raw_chan_w]),
      .fmt_enable (fmt_enable[c]),
      .sign_extend (sign_extend[c]),
      .fmt_type (fmt_type[c]),
      .pn_sel (pn_sel[4*c +: 4]),
      .fmt_data (adc_data[c*fmt_chan_w +: fmt_chan_w]),
      .pn_err (pn_err[c]),
      .pn_oos (pn_oos[c])
    );
  end

endmodule

`default_nettype wire

/* hdl/tpl_adc_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module tpl_adc_regs import tpl_adc_pkg::*; #(
  parameter int num_channels = num_channels_c
) (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_we,
  input logic [7:0] wb_adr,
  input logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic wb_ack,
  output logic [num_channels-1:0] chan_fmt_enable,
  output logic [num_channels-1:0] chan_sign_extend,
  output logic [num_channels-1:0] chan_fmt_type,
  output logic [num_channels*4-1:0] chan_pn_sel,
  output logic sync_arm,
  output logic sync_disarm,
  output logic sync_manual,
  input logic sync_armed,
  input logic [num_channels-1:0] pn_err,
  input logic [num_channels-1:0] pn_oos
);

  logic req;
  logic ack;
  logic wr;
  logic ctrl_wr;
  logic [31:0] rd_data;
  logic [num_channels-1:0] pn_err_sticky;
  logic [num_channels-1:0] sticky_clr;

  // ******************************************************************
  // Wishbone handshake
  // ******************************************************************

  assign req = wb_cyc & wb_stb;
  // The master still holds the request on the ack cycle
  assign wr = ack & req & wb_we;
  assign wb_ack = ack;

  // One wait state, then a single ack cycle per request
  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= req & ~ack;
    end
  end

  always_comb begin
    rd_data = '0;
    if (wb_adr == reg_status_addr_c) begin
      rd_data[0] = sync_armed;
      rd_data[4 +: num_channels] = pn_oos;
      rd_data[8 +: num_channels] = pn_err_sticky;
    end
    for (int c = 0; c < num_channels; c++) begin
      if (wb_adr == 8'(reg_chan_base_c + c)) begin
        rd_data[0] = chan_fmt_enable[c];
        rd_data[1] = chan_sign_extend[c];
        rd_data[2] = chan_fmt_type[c];
        rd_data[7:4] = chan_pn_sel[4*c +: 4];
      end
    end
  end

  // Read data is captured so that it is ready together with ack
  always_ff @(posedge clk) begin
    if (req && !ack) begin
      wb_dat_r <= rd_data;
    end
  end

  // ******************************************************************
  // Channel settings and control pulses
  // ******************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      chan_fmt_enable <= '0;
      chan_sign_extend <= '0;
      chan_fmt_type <= '0;
      chan_pn_sel <= '0;
    end else if (wr) begin
      for (int c = 0; c < num_channels; c++) begin
        if (wb_adr == 8'(reg_chan_base_c + c)) begin
          chan_fmt_enable[c] <= wb_dat_w[0];
          chan_sign_extend[c] <= wb_dat_w[1];
          chan_fmt_type[c] <= wb_dat_w[2];
          chan_pn_sel[4*c +: 4] <= wb_dat_w[7:4];
        end
      end
    end
  end

  // Control bits are never stored and read back as zero
  assign ctrl_wr = wr & (wb_adr == reg_ctrl_addr_c);
  assign sync_arm = ctrl_wr & wb_dat_w[0];
  assign sync_disarm = ctrl_wr & wb_dat_w[1];
  assign sync_manual = ctrl_wr & wb_dat_w[2];

  // Sticky PN errors, a new error in the clearing cycle is kept
  assign sticky_clr = (wr && wb_adr == reg_status_addr_c) ? wb_dat_w[8 +: num_channels] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      pn_err_sticky <= '0;
    end else begin
      pn_err_sticky <= (pn_err_sticky & ~sticky_clr) | pn_err;
    end
  end

endmodule

`default_nettype wire

/* hdl/tpl_adc_ext_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module tpl_adc_ext_sync (
  input logic clk,
  input logic rst,
  input logic arm,
  input logic disarm,
  input logic manual_req,
  input logic ext_enable,
  input logic sync_in,
  output logic armed
);

  logic sync_in_d;
  logic sync_edge;

  // Only a rising edge releases the gate, and only with the external sync on
  assign sync_edge = sync_in & ~sync_in_d & ext_enable;

  always_ff @(posedge clk) begin
    if (rst) begin
      sync_in_d <= 1'b0;
    end else begin
      sync_in_d <= sync_in;
    end
  end

  // Any release event wins over an arm in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      armed <= 1'b0;
    end else if (disarm || manual_req || sync_edge) begin
      armed <= 1'b0;
    end else if (arm && ext_enable) begin
      armed <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/tpl_adc_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module tpl_adc_channel import tpl_adc_pkg::*; #(
  parameter int resolution = resolution_c,
  parameter int sample_bits = sample_bits_c
) (
  input logic clk,
  input logic rst,
  input logic valid,
  input logic [samples_per_beat_c*resolution-1:0] raw_data,
  input logic fmt_enable,
  input logic sign_extend,
  input logic fmt_type,
  input logic [3:0] pn_sel,
  output logic [samples_per_beat_c*sample_bits-1:0] fmt_data,
  output logic pn_err,
  output logic pn_oos
);

  // Bits added on top of the converter value
  localparam int ext_w = sample_bits - resolution;

  logic [samples_per_beat_c*sample_bits-1:0] fmt_next;

  // ******************************************************************
  // Sample formatting
  // ******************************************************************

  always_comb begin
    logic [resolution-1:0] v;
    for (int k = 0; k < samples_per_beat_c; k++) begin
      v = raw_data[k*resolution +: resolution];
      if (!fmt_enable) begin
        // Raw value, zero padded
        fmt_next[k*sample_bits +: sample_bits] = {{ext_w{1'b0}}, v};
      end else begin
        // Offset binary becomes two's complement by flipping the MSB
        v[resolution-1] = v[resolution-1] ^ fmt_type;
        fmt_next[k*sample_bits +: sample_bits] = {{ext_w{sign_extend & v[resolution-1]}}, v};
      end
    end
  end

  // Second pipeline stage, the valid from the core is already aligned with it
  always_ff @(posedge clk) begin
    fmt_data <= fmt_next;
  end

  // The monitor sees exactly the words that leave the channel
  tpl_adc_pn_monitor #(
    .sample_bits (sample_bits)
  ) pn_monitor_inst (
    .clk (clk),
    .rst (rst),
    .valid (valid),
    .data (fmt_data),
    .pn_sel (pn_sel),
    .pn_err (pn_err),
    .pn_oos (pn_oos)
  );

endmodule

`default_nettype wire

/* hdl/tpl_adc_pn_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module tpl_adc_pn_monitor import tpl_adc_pkg::*; #(
  parameter int sample_bits = sample_bits_c
) (
  input logic clk,
  input logic rst,
  input logic valid,
  input logic [samples_per_beat_c*sample_bits-1:0] data,
  input logic [3:0] pn_sel,
  output logic pn_err,
  output logic pn_oos
);

  localparam int data_w = samples_per_beat_c * sample_bits;
  // Enough history for the longest supported polynomial
  localparam int hist_w = 15;

  // Bit 0 of the stream is the oldest bit, the top bit the newest
  logic [hist_w+data_w-1:0] stream;
  logic [hist_w-1:0] hist;
  logic pn7_sel;
  logic pn15_sel;
  logic checking;
  logic mismatch;
  logic [3:0] good_cnt;
  logic [3:0] err_cnt;

  assign pn7_sel = (pn_sel == pn_sel_pn7_c);
  assign pn15_sel = (pn_sel == pn_sel_pn15_c);
  assign checking = pn7_sel | pn15_sel;

  // Lay the beat out in time order behind the carried-over history.
  // Each sample goes out MSB first and sample 0 is sent first
  always_comb begin
    stream[hist_w-1:0] = hist;
    for (int s = 0; s < samples_per_beat_c; s++) begin
      for (int b = 0; b < sample_bits; b++) begin
        stream[hist_w + s*sample_bits + b] = data[s*sample_bits + sample_bits-1-b];
      end
    end
  end

  // ******************************************************************
  // Unrolled predictor, every bit checked against its own past
  // ******************************************************************

  always_comb begin
    mismatch = 1'b0;
    for (int i = hist_w; i < hist_w + data_w; i++) begin
      if (pn7_sel) begin
        // x^7 + x^6 + 1
        mismatch = mismatch | (stream[i] ^ stream[i-6] ^ stream[i-7]);
      end else begin
        // x^15 + x^14 + 1
        mismatch = mismatch | (stream[i] ^ stream[i-14] ^ stream[i-15]);
      end
    end
  end

  // The newest bits seed the prediction of the next valid beat
  always_ff @(posedge clk) begin
    if (valid) begin
      hist <= stream[hist_w+data_w-1 -: hist_w];
    end
  end

  // Out-of-sync hysteresis, 16 beats in a row either way flip the flag
  always_ff @(posedge clk) begin
    if (rst || !checking) begin
      pn_err <= 1'b0;
      pn_oos <= 1'b1;
      good_cnt <= '0;
      err_cnt <= '0;
    end else begin
      pn_err <= valid & mismatch;
      if (valid && mismatch) begin
        good_cnt <= '0;
        if (err_cnt == 4'hf) begin
          pn_oos <= 1'b1;
        end else begin
          err_cnt <= err_cnt + 4'd1;
        end
      end else if (valid) begin
        err_cnt <= '0;
        if (good_cnt == 4'hf) begin
          pn_oos <= 1'b0;
        end else begin
          good_cnt <= good_cnt + 4'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/tpl_adc_deframer.sv */
`timescale 1ns/1ps
`default_nettype none

module tpl_adc_deframer import tpl_adc_pkg::*; #(
  parameter int num_lanes = num_lanes_c,
  parameter int num_channels = num_channels_c,
  parameter int octets_per_beat = octets_per_beat_c,
  parameter int resolution = resolution_c,
  parameter int sample_bits = sample_bits_c
) (
  input logic clk,
  input logic rst,
  input logic [num_lanes*octets_per_beat*8-1:0] link_data,
  output logic [num_channels*samples_per_beat_c*resolution-1:0] raw_data
);

  // Width of one lane and the number of octets that make up a sample
  localparam int lane_w = octets_per_beat * 8;
  localparam int octets_per_sample = sample_bits / 8;
  localparam int raw_chan_w = samples_per_beat_c * resolution;

  // Sample words before the tail bits are dropped
  logic [num_lanes*samples_per_beat_c*sample_bits-1:0] word_s;

  // ******************************************************************
  // Octet to sample mapping
  // ******************************************************************

  // Lane l carries channel l, so the lane loop also walks the channels
  for (genvar l = 0; l < num_lanes; l++) begin : g_lane
    for (genvar k = 0; k < samples_per_beat_c; k++) begin : g_sample
      // The first octet of a sample is its most significant byte
      for (genvar j = 0; j < octets_per_sample; j++) begin : g_octet
        assign word_s[(l*samples_per_beat_c+k)*sample_bits + sample_bits-1-8*j -: 8] =
          link_data[l*lane_w + 8*(k*octets_per_sample+j) +: 8];
      end
    end
  end

  // Only the top resolution bits hold the converter value
  always_ff @(posedge clk) begin
    if (rst) begin
      raw_data <= '0;
    end else begin
      for (int c = 0; c < num_channels; c++) begin
        for (int k = 0; k < samples_per_beat_c; k++) begin
          raw_data[c*raw_chan_w + k*resolution +: resolution] <=
            word_s[(c*samples_per_beat_c+k)*sample_bits + sample_bits-resolution +: resolution];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/tpl_adc_pkg.sv */
`default_nettype none

package tpl_adc_pkg;

  // ******************************************************************
  // Link and converter geometry
  // ******************************************************************

  // Lanes coming from the link layer
  localparam int num_lanes_c = 2;
  // Converter channels, one per lane in this configuration
  localparam int num_channels_c = 2;
  // Octets carried by each lane on every beat
  localparam int octets_per_beat_c = 4;
  // Bits of the converter value inside each sample word
  localparam int resolution_c = 14;
  // Width of a sample word on the link and towards the DMA
  localparam int sample_bits_c = 16;
  // Samples per channel on every beat
  localparam int samples_per_beat_c = 2;

  // ******************************************************************
  // Register map, in word addresses
  // ******************************************************************

  // Sync control, write-only pulses
  localparam logic [7:0] reg_ctrl_addr_c = 8'h00;
  // Sync and PN status
  localparam logic [7:0] reg_status_addr_c = 8'h01;
  // First channel settings word, the others follow one word apart
  localparam logic [7:0] reg_chan_base_c = 8'h04;

  // ******************************************************************
  // PN selector codes
  // ******************************************************************

  // Any other selector value switches the monitor off
  localparam logic [3:0] pn_sel_pn7_c = 4'd1;
  localparam logic [3:0] pn_sel_pn15_c = 4'd2;

endpackage

`default_nettype wire
